//--- all.f
+incdir+include
hw/spi_stream_pkg.sv
hw/spi_engine_pkg.sv
hw/stream_fifo.sv
hw/axis_spi_slave.sv
hw/spi_slave_bridge.sv
tests/spi_slave_bridge_chk.sv
tests/tb_spi_slave_bridge.sv

//--- hw/axis_spi_slave.sv
module axis_spi_slave
    import spi_stream_pkg::*;
    import spi_engine_pkg::*;
(
    input  logic      clk,
    input  logic      rst,

    input  spi_word_t tx_data,
    input  logic      tx_valid,
    output logic      tx_ready,

    output spi_word_t rx_data,
    output logic      rx_last,
    output logic      rx_valid,

    input  logic      cs,
    input  logic      sck,
    input  logic      mosi,
    output logic      miso,

    output logic      busy
);

    localparam int W = $bits(spi_word_t);

    spi_engine_state_t state;
    spi_engine_state_t state_next;

    logic [SPI_BIT_CNT_W-1:0] bit_cnt;
    logic [SPI_BIT_CNT_W-1:0] bit_cnt_next;

    spi_word_t tx_shift;
    spi_word_t tx_shift_next;
    spi_word_t rx_shift;
    spi_word_t rx_shift_next;
    spi_word_t tx_word;

    // set when the word peeked at the last falling edge came from the stream
    logic tx_pending;
    logic tx_pending_next;

    logic tx_ready_q;
    logic tx_ready_next;
    spi_word_t rx_data_q;
    spi_word_t rx_data_next;
    logic rx_last_q;
    logic rx_last_next;
    logic rx_valid_q;
    logic rx_valid_next;
    logic miso_q;
    logic miso_next;

    // one synchroniser stage per pin, plus the previous sck for edge detect
    logic cs_q;
    logic sck_q;
    logic sck_prev;
    logic mosi_q;

    logic sck_rise;
    logic sck_fall;

    assign sck_rise = sck_q && !sck_prev;
    assign sck_fall = !sck_q && sck_prev;

    // zero filler when the host has nothing queued
    assign tx_word = tx_valid ? tx_data : '0;

    assign tx_ready = tx_ready_q;
    assign rx_data  = rx_data_q;
    assign rx_last  = rx_last_q;
    assign rx_valid = rx_valid_q;
    assign miso     = miso_q;
    assign busy     = (state != STATE_IDLE);

    always_comb begin
        state_next      = state;
        bit_cnt_next    = bit_cnt;
        tx_shift_next   = tx_shift;
        rx_shift_next   = rx_shift;
        tx_pending_next = tx_pending;
        tx_ready_next   = 1'b0;
        rx_data_next    = rx_data_q;
        rx_last_next    = rx_last_q;
        rx_valid_next   = 1'b0;
        miso_next       = miso_q;

        case (state)
            STATE_IDLE: begin
                if (cs_q) begin
                    miso_next = 1'b0;
                end else begin
                    // frame start, first bit goes out before the first rising edge
                    miso_next     = tx_word[W-1];
                    tx_shift_next = tx_word << 1;
                    tx_ready_next = tx_valid;
                    rx_shift_next = '0;
                    bit_cnt_next  = SPI_BIT_CNT_W'(W - 1);
                    state_next    = STATE_TRANSFER;
                end
            end

            STATE_TRANSFER: begin
                if (sck_rise) begin
                    rx_shift_next = {rx_shift[W-2:0], mosi_q};
                end else if (sck_fall) begin
                    if (bit_cnt != '0) begin
                        miso_next     = tx_shift[W-1];
                        tx_shift_next = tx_shift << 1;
                        bit_cnt_next  = bit_cnt - 1'b1;
                    end else begin
                        // peek so the next word's msb is on miso before its first rise
                        miso_next       = tx_word[W-1];
                        tx_shift_next   = tx_word << 1;
                        tx_pending_next = tx_valid;
                        state_next      = STATE_WAIT;
                    end
                end else if (cs_q) begin
                    // cs released mid word
                    rx_data_next  = '0;
                    rx_last_next  = 1'b1;
                    rx_valid_next = 1'b1;
                    state_next    = STATE_IDLE;
                end
            end

            STATE_WAIT: begin
                if (cs_q) begin
                    rx_data_next    = rx_shift;
                    rx_last_next    = 1'b1;
                    rx_valid_next   = 1'b1;
                    tx_pending_next = 1'b0;
                    state_next      = STATE_IDLE;
                end else if (sck_rise) begin
                    // next word begins, so the finished one was not the last
                    rx_data_next    = rx_shift;
                    rx_last_next    = 1'b0;
                    rx_valid_next   = 1'b1;
                    tx_ready_next   = tx_pending;
                    tx_pending_next = 1'b0;
                    rx_shift_next   = {{(W - 1){1'b0}}, mosi_q};
                    bit_cnt_next    = SPI_BIT_CNT_W'(W - 1);
                    state_next      = STATE_TRANSFER;
                end
            end

            default: begin
                state_next = STATE_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= STATE_IDLE;
            bit_cnt    <= '0;
            tx_pending <= 1'b0;
            tx_ready_q <= 1'b0;
            rx_valid_q <= 1'b0;
            miso_q     <= 1'b0;
            cs_q       <= 1'b1;
            sck_q      <= 1'b0;
            sck_prev   <= 1'b0;
            mosi_q     <= 1'b0;
        end else begin
            state      <= state_next;
            bit_cnt    <= bit_cnt_next;
            tx_pending <= tx_pending_next;
            tx_ready_q <= tx_ready_next;
            rx_valid_q <= rx_valid_next;
            miso_q     <= miso_next;
            cs_q       <= cs;
            sck_q      <= sck;
            sck_prev   <= sck_q;
            mosi_q     <= mosi;
        end
    end

    always_ff @(posedge clk) begin
        tx_shift  <= tx_shift_next;
        rx_shift  <= rx_shift_next;
        rx_data_q <= rx_data_next;
        rx_last_q <= rx_last_next;
    end

endmodule

//--- hw/spi_engine_pkg.sv
`include "spi_config.svh"

package spi_engine_pkg;

    // width of the bit counter inside a word
    localparam int SPI_BIT_CNT_W = $clog2(`SPI_DATA_WIDTH);

    // wait covers the gap after the last falling edge of a word,
    // until either the next rising edge or cs release
    typedef enum logic [1:0] {
        STATE_IDLE     = 2'd0,
        STATE_TRANSFER = 2'd1,
        STATE_WAIT     = 2'd2
    } spi_engine_state_t;

endpackage

//--- hw/spi_slave_bridge.sv
`include "spi_config.svh"

module spi_slave_bridge
    import spi_stream_pkg::*;
(
    input  logic      clk,
    input  logic      rst,

    input  spi_word_t tx_data,
    input  logic      tx_valid,
    output logic      tx_ready,

    output spi_word_t rx_data,
    output logic      rx_last,
    output logic      rx_valid,
    input  logic      rx_ready,

    input  logic      cs,
    input  logic      sck,
    input  logic      mosi,
    output logic      miso,

    output logic      busy,
    output logic      rx_overflow
);

    spi_word_t    eng_tx_data;
    logic         eng_tx_valid;
    logic         eng_tx_ready;

    spi_word_t    eng_rx_data;
    logic         eng_rx_last;
    logic         eng_rx_valid;

    spi_rx_beat_t rx_beat_out;

    assign rx_data = rx_beat_out.data;
    assign rx_last = rx_beat_out.last;

    stream_fifo #(
        .DEPTH     (`SPI_TX_DEPTH),
        .payload_t (spi_word_t)
    ) u_tx_fifo (
        .clk       (clk),
        .rst       (rst),
        .in_data   (tx_data),
        .in_valid  (tx_valid),
        .in_ready  (tx_ready),
        .out_data  (eng_tx_data),
        .out_valid (eng_tx_valid),
        .out_ready (eng_tx_ready),
        .overflow  ()
    );

    axis_spi_slave u_engine (
        .clk      (clk),
        .rst      (rst),
        .tx_data  (eng_tx_data),
        .tx_valid (eng_tx_valid),
        .tx_ready (eng_tx_ready),
        .rx_data  (eng_rx_data),
        .rx_last  (eng_rx_last),
        .rx_valid (eng_rx_valid),
        .cs       (cs),
        .sck      (sck),
        .mosi     (mosi),
        .miso     (miso),
        .busy     (busy)
    );

    // the engine never stalls, so a beat offered to a full fifo is lost
    stream_fifo #(
        .DEPTH     (`SPI_RX_DEPTH),
        .payload_t (spi_rx_beat_t)
    ) u_rx_fifo (
        .clk       (clk),
        .rst       (rst),
        .in_data   ({eng_rx_data, eng_rx_last}),
        .in_valid  (eng_rx_valid),
        .in_ready  (),
        .out_data  (rx_beat_out),
        .out_valid (rx_valid),
        .out_ready (rx_ready),
        .overflow  (rx_overflow)
    );

endmodule

//--- hw/spi_stream_pkg.sv
`include "spi_config.svh"

package spi_stream_pkg;

    // one spi word, the transmit stream payload
    typedef logic [`SPI_DATA_WIDTH-1:0] spi_word_t;

    // receive stream payload
    // last marks the final word of a frame, or an aborted frame
    typedef struct packed {
        spi_word_t data;
        logic      last;
    } spi_rx_beat_t;

endpackage

//--- hw/stream_fifo.sv
module stream_fifo
    import spi_stream_pkg::*;
#(
    parameter int  DEPTH     = 4,
    parameter type payload_t = spi_word_t
) (
    input  logic     clk,
    input  logic     rst,

    input  payload_t in_data,
    input  logic     in_valid,
    output logic     in_ready,

    output payload_t out_data,
    output logic     out_valid,
    input  logic     out_ready,

    output logic     overflow
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t mem [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             full;
    logic             empty;
    logic             push;
    logic             pop;

    // wrap at DEPTH so non power of two depths work too
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        logic [PTR_W-1:0] next_ptr;
        if (ptr == PTR_W'(DEPTH - 1)) begin
            next_ptr = '0;
        end else begin
            next_ptr = ptr + 1'b1;
        end
        return next_ptr;
    endfunction

    assign full  = (count == CNT_W'(DEPTH));
    assign empty = (count == '0);

    assign push = in_valid && !full;
    assign pop  = out_valid && out_ready;

    assign in_ready  = !full;
    assign out_valid = !empty;
    assign out_data  = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_data;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end

            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase

            // sticky until reset
            if (in_valid && full) begin
                overflow <= 1'b1;
            end
        end
    end

endmodule

//--- include/spi_config.svh
`ifndef SPI_CONFIG_SVH
`define SPI_CONFIG_SVH

// bits per spi word, shifted msb first
`define SPI_DATA_WIDTH 8

// host to engine queue, sized to hold a full frame of words
`define SPI_TX_DEPTH 8

// engine to host queue
// beats arriving while this is full are dropped
`define SPI_RX_DEPTH 4

`endif

//--- tests/spi_slave_bridge_chk.sv
module spi_slave_bridge_chk
    import spi_stream_pkg::*;
    import spi_engine_pkg::*;
(
    input logic              clk,
    input logic              rst,
    input spi_word_t         rx_data,
    input logic              rx_last,
    input logic              rx_valid,
    input logic              rx_ready,
    input logic              eng_tx_valid,
    input logic              eng_tx_ready,
    input logic              cs,
    input logic              busy,
    input spi_engine_state_t state
);

    int fail_count = 0;

    // a stalled rx beat stays put until the host takes it
    rx_hold_a: assert property (@(posedge clk) disable iff (rst)
        rx_valid && !rx_ready |=> rx_valid && $stable(rx_data) && $stable(rx_last))
    else begin
        $error("rx beat changed or vanished while rx_ready was low");
        fail_count++;
    end

    // engine only pops a word that the tx fifo offers
    tx_ready_a: assert property (@(posedge clk) disable iff (rst)
        eng_tx_ready |-> eng_tx_valid)
    else begin
        $error("engine tx_ready high while tx_valid low");
        fail_count++;
    end

    // an idle engine stays idle while cs is high
    idle_busy_a: assert property (@(posedge clk) disable iff (rst)
        state == STATE_IDLE && cs |=> !busy)
    else begin
        $error("busy went high while cs was high and the engine was idle");
        fail_count++;
    end

endmodule

bind spi_slave_bridge spi_slave_bridge_chk u_chk (
    .clk          (clk),
    .rst          (rst),
    .rx_data      (rx_data),
    .rx_last      (rx_last),
    .rx_valid     (rx_valid),
    .rx_ready     (rx_ready),
    .eng_tx_valid (eng_tx_valid),
    .eng_tx_ready (eng_tx_ready),
    .cs           (cs),
    .busy         (busy),
    .state        (u_engine.state)
);

//--- tests/spi_testdata.txt
// six lines per frame, eight hex words per line
// 1: kind (1 full, 2 aborted, 3 rx held low), full words, extra bits, tx words, rx beats
// 2: tx words  3: mosi words  4: expected miso, a part word right aligned
// 5: expected rx beat data  6: expected rx beat last
01 04 00 04 04 00 00 00
a5 3c 0f f0 00 00 00 00
11 22 33 44 00 00 00 00
a5 3c 0f f0 00 00 00 00
11 22 33 44 00 00 00 00
00 00 00 01 00 00 00 00
01 05 00 02 05 00 00 00
c3 81 00 00 00 00 00 00
de ad be ef 01 00 00 00
c3 81 00 00 00 00 00 00
de ad be ef 01 00 00 00
00 00 00 00 01 00 00 00
01 03 00 00 03 00 00 00
00 00 00 00 00 00 00 00
5a 69 96 00 00 00 00 00
00 00 00 00 00 00 00 00
5a 69 96 00 00 00 00 00
00 00 01 00 00 00 00 00
02 02 03 03 03 00 00 00
12 34 e7 00 00 00 00 00
77 88 a0 00 00 00 00 00
12 34 07 00 00 00 00 00
77 88 00 00 00 00 00 00
00 00 01 00 00 00 00 00
03 06 00 06 04 00 00 00
01 02 04 08 10 20 00 00
31 32 33 34 35 36 00 00
01 02 04 08 10 20 00 00
31 32 33 34 00 00 00 00
00 00 00 00 00 00 00 00
02 00 05 01 01 00 00 00
9c 00 00 00 00 00 00 00
ff 00 00 00 00 00 00 00
13 00 00 00 00 00 00 00
00 00 00 00 00 00 00 00
01 00 00 00 00 00 00 00

//--- tests/tb_spi_slave_bridge.sv
`include "spi_config.svh"

module tb_spi_slave_bridge
    import spi_stream_pkg::*;
();

    localparam int W           = `SPI_DATA_WIDTH;
    localparam int HALF_SCK    = 4;
    localparam int NUM_FRAMES  = 6;
    localparam int REC_WORDS   = 48;
    localparam int WAIT_LIMIT  = 400;
    // nine words of up to 80 cycles per frame, plus margin for queueing and draining
    localparam int CYCLE_LIMIT = NUM_FRAMES * 9 * 80 + 1000;

    localparam logic [7:0] KIND_HOLD = 8'h03;

    logic      clk;
    logic      rst;
    spi_word_t tx_data;
    logic      tx_valid;
    logic      tx_ready;
    spi_word_t rx_data;
    logic      rx_last;
    logic      rx_valid;
    logic      rx_ready;
    logic      cs;
    logic      sck;
    logic      mosi;
    logic      miso;
    logic      busy;
    logic      rx_overflow;

    logic [7:0]   testdata [NUM_FRAMES * REC_WORDS];
    spi_rx_beat_t rx_got [$];
    int           error_count = 0;
    int           cycle_count = 0;

    spi_slave_bridge u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: run did not complete within %0d clock cycles", CYCLE_LIMIT);
        error_count++;
        finish_run();
    end

    // every beat the host accepts
    always @(posedge clk) begin
        if (!rst && rx_valid && rx_ready) begin
            rx_got.push_back(spi_rx_beat_t'{data: rx_data, last: rx_last});
        end
    end

    task automatic check_word(input string name, input spi_word_t exp, input spi_word_t act);
        if (act !== exp) begin
            error_count++;
            $display("CHECK FAILED %s expected %h got %h", name, exp, act);
        end
    endtask

    task automatic check_beat(input string name, input spi_rx_beat_t exp,
                              input spi_rx_beat_t act);
        if (act !== exp) begin
            error_count++;
            $display("CHECK FAILED %s expected data %h last %h got data %h last %h",
                     name, exp.data, exp.last, act.data, act.last);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            error_count++;
            $display("CHECK FAILED %s expected %h got %h", name, exp, act);
        end
    endtask

    task automatic reset_dut();
        rst = 1'b1;
        repeat (2) @(negedge clk);
        rst = 1'b0;
    endtask

    // starts and ends on a falling clk edge
    task automatic push_tx(input spi_word_t value);
        logic accepted;
        tx_data  = value;
        tx_valid = 1'b1;
        accepted = 1'b0;
        while (!accepted) begin
            @(posedge clk);
            accepted = tx_ready;
        end
        @(negedge clk);
        tx_valid = 1'b0;
    endtask

    // mode 0 master, msb first, miso bits collected right aligned
    task automatic spi_shift(input spi_word_t out_word, input int nbits,
                             output spi_word_t in_word);
        in_word = '0;
        for (int i = 0; i < nbits; i++) begin
            mosi = out_word[W - 1 - i];
            repeat (HALF_SCK) @(negedge clk);
            sck     = 1'b1;
            in_word = {in_word[W-2:0], miso};
            repeat (HALF_SCK) @(negedge clk);
            sck = 1'b0;
        end
    endtask

    task automatic run_frame(input int frame);
        int           base;
        int           nbytes;
        int           nbits;
        int           nbeats;
        int           waited;
        logic         hold;
        spi_word_t    got;
        spi_rx_beat_t exp;

        base = frame * REC_WORDS;
        if ($isunknown(testdata[base])) begin
            error_count++;
            $display("test data for frame %0d is missing", frame);
            return;
        end
        nbytes = testdata[base + 1];
        nbits  = testdata[base + 2];
        nbeats = testdata[base + 4];
        hold   = (testdata[base] == KIND_HOLD);
        rx_got.delete();

        @(negedge clk);
        for (int i = 0; i < testdata[base + 3]; i++) begin
            push_tx(testdata[base + 8 + i]);
        end
        check_flag("busy before frame", 1'b0, busy);
        rx_ready = !hold;
        cs       = 1'b0;
        for (int i = 0; i < nbytes; i++) begin
            spi_shift(testdata[base + 16 + i], W, got);
            check_word($sformatf("miso frame %0d word %0d", frame, i),
                       testdata[base + 24 + i], got);
            check_flag("busy during frame", 1'b1, busy);
        end
        if (nbits != 0) begin
            spi_shift(testdata[base + 16 + nbytes], nbits, got);
            check_word($sformatf("miso frame %0d part word", frame),
                       testdata[base + 24 + nbytes], got);
        end
        repeat (HALF_SCK) @(negedge clk);
        cs = 1'b1;

        waited = 0;
        while ((busy || (hold && !rx_overflow)) && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (busy) begin
            error_count++;
            $display("frame %0d: engine still busy long after cs release", frame);
        end
        if (hold) begin
            check_flag("rx_overflow while rx held", 1'b1, rx_overflow);
            rx_ready = 1'b1;
        end

        waited = 0;
        while (rx_got.size() < nbeats && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (rx_got.size() < nbeats) begin
            error_count++;
            $display("frame %0d: only %0d of %0d rx beats arrived", frame, rx_got.size(), nbeats);
        end else if (rx_valid) begin
            error_count++;
            $display("frame %0d: rx stream offers more beats than expected", frame);
        end
        for (int i = 0; i < nbeats && i < rx_got.size(); i++) begin
            exp.data = testdata[base + 32 + i];
            exp.last = testdata[base + 40 + i][0];
            check_beat($sformatf("rx_data/rx_last frame %0d beat %0d", frame, i), exp, rx_got[i]);
        end

        if (hold) begin
            reset_dut();
            check_flag("rx_overflow after reset", 1'b0, rx_overflow);
        end
    endtask

    task automatic finish_run();
        int assert_fails;
        assert_fails = u_dut.u_chk.fail_count;
        $display("errors: %0d failed checks, %0d failed assertions", error_count, assert_fails);
        if (error_count == 0 && assert_fails == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    endtask

    initial begin
        rst      = 1'b1;
        tx_data  = '0;
        tx_valid = 1'b0;
        rx_ready = 1'b1;
        cs       = 1'b1;
        sck      = 1'b0;
        mosi     = 1'b0;
        $readmemh("tests/spi_testdata.txt", testdata);
        reset_dut();
        check_flag("rx_valid after reset", 1'b0, rx_valid);
        check_flag("miso after reset", 1'b0, miso);
        check_flag("busy after reset", 1'b0, busy);
        check_flag("rx_overflow after reset", 1'b0, rx_overflow);
        for (int f = 0; f < NUM_FRAMES; f++) begin
            run_frame(f);
        end
        finish_run();
    end

endmodule
